// File: Makefile
# Verilator build and run for the global controller testbench

VERILATOR ?= verilator
TOP       ?= tb_gc_global_controller
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard verilog/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/gc_golden.mem
// columns: kind op dtype row col bank word, all hex, one record per line
// kind 1 is a request, kind 2 the expected word of the read above it, kind F ends the list
1 1 0 10 01 0 11110001
1 1 1 20 02 1 22220002
1 0 0 10 01 0 00000000
2 0 0 00 00 0 11110001
1 0 1 30 03 2 00000000
2 0 0 00 00 0 C230033C
1 0 1 20 02 1 00000000
2 0 0 00 00 0 22220002
1 0 2 40 04 3 00000000
2 0 0 00 00 0 C340043C
1 1 2 31 05 2 33330003
1 1 2 31 05 2 33330004
1 0 2 31 05 2 00000000
2 0 0 00 00 0 33330004
// burst of writes past the flush level
1 1 0 50 10 0 44440010
1 1 0 51 11 1 44440011
1 1 1 52 12 2 44440012
1 1 1 53 13 3 44440013
1 1 2 54 14 0 44440014
1 1 2 55 15 1 44440015
1 0 0 53 13 3 00000000
2 0 0 00 00 0 44440013
1 0 0 50 10 0 00000000
2 0 0 00 00 0 44440010
1 0 1 61 20 1 00000000
2 0 0 00 00 0 C161203C
1 0 1 54 14 0 00000000
2 0 0 00 00 0 44440014
1 0 2 62 3F 2 00000000
2 0 0 00 00 0 C2623F3C
1 0 2 55 15 1 00000000
2 0 0 00 00 0 44440015
1 0 0 52 12 2 00000000
2 0 0 00 00 0 44440012
1 0 0 51 11 1 00000000
2 0 0 00 00 0 44440011
F 0 0 00 00 0 00000000

// File: dv/tb_gc_global_controller.sv
/*
 * Testbench for the global controller. Requests and expected read words
 * come from dv/gc_golden.mem, so the run starts in the project root.
 * Bank models take every command at once and return reads after random delays.
 */
`timescale 1ns/1ns

`include "gc_cfg.svh"

module tb_gc_global_controller import gc_cmd_pkg::*, gc_bank_pkg::*;;

    localparam int NB             = `GC_NUM_BANKS;
    localparam int REC_WORDS      = 7;
    localparam int GOLDEN_WORDS   = REC_WORDS * 64;
    localparam int CYCLES_PER_REQ = 200;

    logic          clk;
    logic          rst_n;
    logic          req_valid;
    gc_front_cmd_t req_cmd;
    gc_word_t      req_wdata;
    logic          req_ready;
    logic          rd_valid;
    gc_word_t      rd_data;
    logic [NB-1:0] bank_ready;
    logic [NB-1:0] bank_cmd_valid;
    gc_bank_cmd_t  bank_cmd [NB];
    gc_word_t      bank_wdata [NB];
    logic [NB-1:0] bank_ret_valid;
    gc_word_t      bank_ret_data [NB];
    logic [NB-1:0] bank_ren;

    // golden records, see the column line at the top of the file
    logic [31:0]   golden [GOLDEN_WORDS];
    gc_front_cmd_t req_cmds [$];
    gc_word_t      req_words [$];
    gc_word_t      exp_rd [$];
    gc_bank_cmd_t  exp_rd_cmd [NB][$];
    gc_bank_cmd_t  exp_wr_cmd [NB][$];
    gc_word_t      exp_wr_word [NB][$];

    // bank model state
    gc_word_t      ret_q [NB][$];
    gc_word_t      bank_mem [int];

    int            n_reads;
    int            rd_seen;
    int            timeout_cycles;
    integer        seed = 32'h74b;

    gc_global_controller gc_global_controller_inst (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_req_valid      (req_valid),
        .i_req_cmd        (req_cmd),
        .i_req_wdata      (req_wdata),
        .o_req_ready      (req_ready),
        .o_rd_valid       (rd_valid),
        .o_rd_data        (rd_data),
        .i_bank_ready     (bank_ready),
        .o_bank_cmd_valid (bank_cmd_valid),
        .o_bank_cmd       (bank_cmd),
        .o_bank_wdata     (bank_wdata),
        .i_bank_ret_valid (bank_ret_valid),
        .i_bank_ret_data  (bank_ret_data),
        .o_bank_ren       (bank_ren)
    );

    initial
        clk = 1'b0;

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bank_cmd(input int b, input gc_bank_cmd_t got,
                                  input gc_bank_cmd_t exp);
        if (got != exp)
            abort_run($sformatf("CHECK FAILED at time %0t: bank %0d command %h, expected %h",
                                $time, b, got, exp));
    endtask

    task automatic check_wr_word(input int b, input gc_word_t got, input gc_word_t exp);
        if (got != exp)
            abort_run($sformatf("CHECK FAILED at time %0t: bank %0d write word %h, expected %h",
                                $time, b, got, exp));
    endtask

    task automatic check_rd_word(input gc_word_t got, input gc_word_t exp);
        if (got != exp)
            abort_run($sformatf("CHECK FAILED at time %0t: read %0d word %h, expected %h",
                                $time, rd_seen, got, exp));
    endtask

    // unwritten locations read back a pattern built from the full address
    function automatic gc_word_t fill_word(input gc_bank_sel_t sel,
                                           input logic [`GC_ROW_BITS-1:0] row,
                                           input logic [`GC_COL_BITS-1:0] col);
        return {4'hC, 2'b00, sel, row, 2'b00, col, 8'h3C};
    endfunction

    function automatic int addr_key(input gc_bank_sel_t sel,
                                    input logic [`GC_ROW_BITS-1:0] row,
                                    input logic [`GC_COL_BITS-1:0] col);
        return int'({sel, row, col});
    endfunction

    function automatic int cmds_left();
        int total;
        total = 0;
        for (int b = 0; b < NB; b++)
            total += exp_rd_cmd[b].size() + exp_wr_cmd[b].size();
        return total;
    endfunction

    task automatic load_golden();
        int            idx;
        bit            done;
        gc_front_cmd_t cmd;
        gc_bank_cmd_t  bcmd;
        idx     = 0;
        done    = 1'b0;
        n_reads = 0;
        $readmemh("dv/gc_golden.mem", golden);
        while (!done)
        begin
            if (idx + REC_WORDS > GOLDEN_WORDS)
                abort_run("golden file has no end record");
            else if (golden[idx] == 32'h1)
            begin
                cmd.op        = gc_op_e'(golden[idx + 1][0]);
                cmd.data_type = gc_data_type_e'(golden[idx + 2][1:0]);
                cmd.row       = golden[idx + 3][`GC_ROW_BITS-1:0];
                cmd.col       = golden[idx + 4][`GC_COL_BITS-1:0];
                cmd.bank      = golden[idx + 5][`GC_BANK_BITS-1:0];
                bcmd          = '{op: cmd.op, data_type: cmd.data_type,
                                  row: cmd.row, col: cmd.col};
                req_cmds.push_back(cmd);
                req_words.push_back(golden[idx + 6]);
                if (cmd.op == GC_OP_WRITE)
                begin
                    exp_wr_cmd[cmd.bank].push_back(bcmd);
                    exp_wr_word[cmd.bank].push_back(golden[idx + 6]);
                end
                else
                begin
                    exp_rd_cmd[cmd.bank].push_back(bcmd);
                    n_reads++;
                end
            end
            else if (golden[idx] == 32'h2)
                exp_rd.push_back(golden[idx + 6]);
            else if (golden[idx] == 32'hF)
                done = 1'b1;
            else
                abort_run($sformatf("golden record %0d has an unknown kind", idx / REC_WORDS));
            idx += REC_WORDS;
        end
        if (exp_rd.size() != n_reads)
            abort_run($sformatf("golden file lists %0d read words for %0d reads",
                                exp_rd.size(), n_reads));
        timeout_cycles = req_cmds.size() * CYCLES_PER_REQ;
    endtask

    task automatic check_idle();
        string msg;
        if (bank_cmd_valid != '0 || bank_ren != '0 || rd_valid || !req_ready)
        begin
            msg = $sformatf("CHECK FAILED at time %0t: after reset cmd_valid %b ren %b",
                            $time, bank_cmd_valid, bank_ren);
            abort_run($sformatf("%s rd_valid %b ready %b", msg, rd_valid, req_ready));
        end
    endtask

    // holds valid until the DUT takes the request
    task automatic send_request(input gc_front_cmd_t cmd, input gc_word_t word);
        logic taken;
        taken     = 1'b0;
        req_valid = 1'b1;
        req_cmd   = cmd;
        req_wdata = word;
        while (!taken)
        begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bank models
    ////////////////////////////////////////////////////////////////////////////

    task automatic take_bank_cmd(input int b);
        gc_bank_cmd_t cmd;
        gc_bank_sel_t sel;
        int           key;
        cmd = bank_cmd[b];
        sel = gc_bank_sel_t'(b);
        key = addr_key(sel, cmd.row, cmd.col);
        if (cmd.op == GC_OP_WRITE)
        begin
            if (exp_wr_cmd[b].size() == 0)
                abort_run($sformatf("bank %0d received a write no request asked for", b));
            else
            begin
                check_bank_cmd(b, cmd, exp_wr_cmd[b].pop_front());
                check_wr_word(b, bank_wdata[b], exp_wr_word[b].pop_front());
                bank_mem[key] = bank_wdata[b];
            end
        end
        else if (exp_rd_cmd[b].size() == 0)
            abort_run($sformatf("bank %0d received a read no request asked for", b));
        else
        begin
            check_bank_cmd(b, cmd, exp_rd_cmd[b].pop_front());
            if (bank_mem.exists(key))
                ret_q[b].push_back(bank_mem[key]);
            else
                ret_q[b].push_back(fill_word(sel, cmd.row, cmd.col));
        end
    endtask

    // random ready and return timing, driven just after the edge
    always @(posedge clk)
    begin
        #1;
        for (int b = 0; b < NB; b++)
        begin
            bank_ready[b]     = ($random(seed) & 1) != 0;
            bank_ret_valid[b] = (ret_q[b].size() != 0) && (($random(seed) & 1) != 0);
            bank_ret_data[b]  = (ret_q[b].size() != 0) ? ret_q[b][0] : '0;
        end
    end

    task automatic take_rd_beat();
        if (exp_rd.size() == 0)
            abort_run("read data came out with no read outstanding");
        else
        begin
            check_rd_word(rd_data, exp_rd.pop_front());
            rd_seen++;
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            for (int b = 0; b < NB; b++)
            begin
                if (bank_cmd_valid[b])
                    take_bank_cmd(b);
                if (bank_ren[b] && bank_ret_valid[b])
                    void'(ret_q[b].pop_front());
            end
            if (rd_valid)
                take_rd_beat();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_cmd        = '0;
        req_wdata      = '0;
        bank_ready     = '0;
        bank_ret_valid = '0;
        for (int b = 0; b < NB; b++)
            bank_ret_data[b] = '0;
        rd_seen = 0;
        load_golden();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;
        for (int i = 0; i < req_cmds.size(); i++)
            send_request(req_cmds[i], req_words[i]);
        req_valid = 1'b0;
        while (rd_seen < n_reads || cmds_left() != 0)
            @(negedge clk);
        // idle a while to catch stray beats
        repeat (20) @(negedge clk);
        if (rd_seen == n_reads && cmds_left() == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
            abort_run($sformatf("saw %0d read beats for %0d reads", rd_seen, n_reads));
    end

    initial
    begin
        @(posedge rst_n);
        repeat (timeout_cycles) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, the DUT did not finish",
                            timeout_cycles));
    end

endmodule

// File: files.f
+incdir+verilog
verilog/gc_cmd_pkg.sv
verilog/gc_bank_pkg.sv
verilog/gc_sync_fifo.sv
verilog/gc_write_queue.sv
verilog/gc_request_scheduler.sv
verilog/gc_bank_dispatch.sv
verilog/gc_global_controller.sv
dv/tb_gc_global_controller.sv

// File: verilog/gc_bank_dispatch.sv
/*
 * Routes the scheduled head to its bank and returns read data in request
 * order. A bank must take a command the cycle its valid is high. Returns
 * from any bank other than the oldest outstanding read are held off.
 */
`timescale 1ns/1ns

`include "gc_cfg.svh"

module gc_bank_dispatch import gc_cmd_pkg::*, gc_bank_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  gc_sched_entry_t          i_sched_head,
    input  logic                     i_sched_empty,
    output logic                     o_sched_pop,
    input  logic [`GC_NUM_BANKS-1:0] i_bank_ready,
    output logic [`GC_NUM_BANKS-1:0] o_bank_cmd_valid,
    output gc_bank_cmd_t             o_bank_cmd [`GC_NUM_BANKS],
    output gc_word_t                 o_bank_wdata [`GC_NUM_BANKS],
    input  logic [`GC_NUM_BANKS-1:0] i_bank_ret_valid,
    input  gc_word_t                 i_bank_ret_data [`GC_NUM_BANKS],
    output logic [`GC_NUM_BANKS-1:0] o_bank_ren,
    output logic                     o_rd_valid,
    output gc_word_t                 o_rd_data
);

    localparam int NB = `GC_NUM_BANKS;

    gc_bank_sel_t    head_bank;
    logic            head_is_read;
    logic [NB-1:0]   issue;

    gc_bank_sel_t    ro_head;
    logic            ro_empty;
    logic            ro_full;
    logic            ro_push;
    logic            ret_hs;
    logic            ret_valid;
    gc_word_t        ret_word;

    ////////////////////////////////////////////////////////////////////////////
    // command issue
    ////////////////////////////////////////////////////////////////////////////

    assign head_bank    = i_sched_head.cmd.bank;
    assign head_is_read = (i_sched_head.cmd.op == GC_OP_READ);

    // a read also needs room to record its bank
    assign o_sched_pop = !i_sched_empty && i_bank_ready[head_bank] &&
                         !(head_is_read && ro_full);

    always_comb
    begin
        issue = '0;
        if (o_sched_pop)
            issue[head_bank] = 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_bank_cmd_valid <= '0;
        else
            o_bank_cmd_valid <= issue;
    end

    for (genvar b = 0; b < NB; b++)
    begin : g_bank
        always_ff @(posedge i_clk)
        begin
            if (issue[b])
            begin
                o_bank_cmd[b]   <= '{op:        i_sched_head.cmd.op,
                                     data_type: i_sched_head.cmd.data_type,
                                     row:       i_sched_head.cmd.row,
                                     col:       i_sched_head.cmd.col};
                o_bank_wdata[b] <= i_sched_head.wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // in-order read return
    ////////////////////////////////////////////////////////////////////////////

    assign ro_push = o_sched_pop && head_is_read;

    gc_sync_fifo #(
        .WIDTH (`GC_BANK_BITS),
        .DEPTH (`GC_FIFO_DEPTH)
    ) read_order_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (ro_push),
        .i_pop   (ret_hs),
        .i_data  (head_bank),
        .o_data  (ro_head),
        .o_empty (ro_empty),
        .o_full  (ro_full),
        .o_count ()
    );

    // only the oldest outstanding read may return
    always_comb
    begin
        o_bank_ren = '0;
        if (!ro_empty)
            o_bank_ren[ro_head] = 1'b1;
    end

    assign ret_hs = |(o_bank_ren & i_bank_ret_valid);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            ret_valid  <= 1'b0;
            o_rd_valid <= 1'b0;
        end
        else
        begin
            ret_valid  <= ret_hs;
            o_rd_valid <= ret_valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (ret_hs)
            ret_word <= i_bank_ret_data[ro_head];
        if (ret_valid)
            o_rd_data <= ret_word;
    end

    a_single_cmd : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_bank_cmd_valid) && $onehot0(o_bank_ren));

endmodule

// File: verilog/gc_bank_pkg.sv
/*
 * Bank-side types. A scheduled entry carries its write word with it;
 * for reads the word is zero.
 */
`include "gc_cfg.svh"

package gc_bank_pkg;

    import gc_cmd_pkg::*;

    // what a bank controller sees, the bank field is implied by the port
    typedef struct packed
    {
        gc_op_e                  op;
        gc_data_type_e           data_type;
        logic [`GC_ROW_BITS-1:0] row;
        logic [`GC_COL_BITS-1:0] col;
    } gc_bank_cmd_t;

    typedef struct packed
    {
        gc_front_cmd_t cmd;
        gc_word_t      wdata;
    } gc_sched_entry_t;

    typedef logic [`GC_BANK_BITS-1:0] gc_bank_sel_t;

endpackage

// File: verilog/gc_cfg.svh
/*
 * Sizing for the global controller. GC_WQ_FLUSH_LEVEL must stay below
 * GC_WQ_DEPTH - 1, because up to two writes can arrive after a flush starts.
 */
`ifndef GC_CFG_SVH
`define GC_CFG_SVH

// data and address widths
`define GC_WORD_BITS      32
`define GC_ROW_BITS       8
`define GC_COL_BITS       6
`define GC_BANK_BITS      2
`define GC_NUM_BANKS      4

// queue sizing
`define GC_FIFO_DEPTH     8
`define GC_WQ_DEPTH       8
`define GC_WQ_FLUSH_LEVEL 4

`endif

// File: verilog/gc_cmd_pkg.sv
/*
 * Request-side types as the host sees them. Field order in the command
 * struct is fixed and matches the stimulus files.
 */
`include "gc_cfg.svh"

package gc_cmd_pkg;

    typedef enum logic
    {
        GC_OP_READ  = 1'b0,
        GC_OP_WRITE = 1'b1
    } gc_op_e;

    typedef enum logic [1:0]
    {
        GC_DT_WEIGHTS     = 2'd0,
        GC_DT_ACTIVATIONS = 2'd1,
        GC_DT_OUTPUT      = 2'd2
    } gc_data_type_e;

    // 19 bits at the default sizes
    typedef struct packed
    {
        gc_op_e                   op;
        gc_data_type_e            data_type;
        logic [`GC_ROW_BITS-1:0]  row;
        logic [`GC_COL_BITS-1:0]  col;
        logic [`GC_BANK_BITS-1:0] bank;
    } gc_front_cmd_t;

    typedef logic [`GC_WORD_BITS-1:0] gc_word_t;

endpackage

// File: verilog/gc_global_controller.sv
/*
 * Global controller in front of the bank controllers. Read data returns
 * in request order with no back-pressure on the host read channel.
 */
`timescale 1ns/1ns

`include "gc_cfg.svh"

module gc_global_controller import gc_cmd_pkg::*, gc_bank_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,

    // host request channel
    input  logic                     i_req_valid,
    input  gc_front_cmd_t            i_req_cmd,
    input  gc_word_t                 i_req_wdata,
    output logic                     o_req_ready,

    // host read channel
    output logic                     o_rd_valid,
    output gc_word_t                 o_rd_data,

    // bank command channels
    input  logic [`GC_NUM_BANKS-1:0] i_bank_ready,
    output logic [`GC_NUM_BANKS-1:0] o_bank_cmd_valid,
    output gc_bank_cmd_t             o_bank_cmd [`GC_NUM_BANKS],
    output gc_word_t                 o_bank_wdata [`GC_NUM_BANKS],

    // bank return channels
    input  logic [`GC_NUM_BANKS-1:0] i_bank_ret_valid,
    input  gc_word_t                 i_bank_ret_data [`GC_NUM_BANKS],
    output logic [`GC_NUM_BANKS-1:0] o_bank_ren
);

    gc_sched_entry_t sched_head;
    logic            sched_empty;
    logic            sched_pop;

    gc_request_scheduler request_scheduler_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req_cmd     (i_req_cmd),
        .i_req_wdata   (i_req_wdata),
        .o_req_ready   (o_req_ready),
        .i_sched_pop   (sched_pop),
        .o_sched_head  (sched_head),
        .o_sched_empty (sched_empty)
    );

    gc_bank_dispatch bank_dispatch_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_sched_head     (sched_head),
        .i_sched_empty    (sched_empty),
        .o_sched_pop      (sched_pop),
        .i_bank_ready     (i_bank_ready),
        .o_bank_cmd_valid (o_bank_cmd_valid),
        .o_bank_cmd       (o_bank_cmd),
        .o_bank_wdata     (o_bank_wdata),
        .i_bank_ret_valid (i_bank_ret_valid),
        .i_bank_ret_data  (i_bank_ret_data),
        .o_bank_ren       (o_bank_ren),
        .o_rd_valid       (o_rd_valid),
        .o_rd_data        (o_rd_data)
    );

endmodule

// File: verilog/gc_request_scheduler.sv
/*
 * Front end: registers the host request, sorts it into the read or write
 * queue and feeds one entry per cycle into the scheduled queue. Reads win
 * unless the write queue is flushing.
 */
`timescale 1ns/1ns

`include "gc_cfg.svh"

module gc_request_scheduler import gc_cmd_pkg::*, gc_bank_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_req_valid,
    input  gc_front_cmd_t   i_req_cmd,
    input  gc_word_t        i_req_wdata,
    output logic            o_req_ready,
    input  logic            i_sched_pop,
    output gc_sched_entry_t o_sched_head,
    output logic            o_sched_empty
);

    localparam int CW = $clog2(`GC_FIFO_DEPTH + 1);

    logic            req_valid_q;
    gc_front_cmd_t   req_cmd_q;
    gc_word_t        req_wdata_q;
    logic            rd_push;
    logic            wr_push;

    gc_front_cmd_t   rq_head;
    logic            rq_empty;
    logic            rq_full;
    logic [CW-1:0]   rq_count;
    logic            rq_room;
    logic            rq_pop;

    gc_sched_entry_t wq_head;
    logic            wq_empty;
    logic            wq_full;
    logic            wq_flush;
    logic            wq_pop;

    logic            sq_full;
    logic            sq_push;
    logic            pick_write;
    gc_sched_entry_t sq_in;

    ////////////////////////////////////////////////////////////////////////////
    // host request register
    ////////////////////////////////////////////////////////////////////////////

    // a request already registered still needs a read queue slot
    assign rq_room     = rd_push ? (rq_count < CW'(`GC_FIFO_DEPTH - 1)) : !rq_full;
    assign o_req_ready = rq_room && !wq_full && !wq_flush;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            req_valid_q <= 1'b0;
        else
            req_valid_q <= i_req_valid && o_req_ready;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_req_valid && o_req_ready)
        begin
            req_cmd_q   <= i_req_cmd;
            req_wdata_q <= i_req_wdata;
        end
    end

    assign rd_push = req_valid_q && (req_cmd_q.op == GC_OP_READ);
    assign wr_push = req_valid_q && (req_cmd_q.op == GC_OP_WRITE);

    ////////////////////////////////////////////////////////////////////////////
    // read and write queues
    ////////////////////////////////////////////////////////////////////////////

    gc_sync_fifo #(
        .WIDTH ($bits(gc_front_cmd_t)),
        .DEPTH (`GC_FIFO_DEPTH)
    ) read_queue_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rd_push),
        .i_pop   (rq_pop),
        .i_data  (req_cmd_q),
        .o_data  (rq_head),
        .o_empty (rq_empty),
        .o_full  (rq_full),
        .o_count (rq_count)
    );

    // the registered read probes for an older write to its address
    gc_write_queue write_queue_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_push        (wr_push),
        .i_cmd         (req_cmd_q),
        .i_wdata       (req_wdata_q),
        .i_pop         (wq_pop),
        .i_raw_probe   (req_cmd_q),
        .i_probe_valid (rd_push),
        .o_head        (wq_head),
        .o_empty       (wq_empty),
        .o_full        (wq_full),
        .o_flush       (wq_flush)
    );

    ////////////////////////////////////////////////////////////////////////////
    // arbitration into the scheduled queue
    ////////////////////////////////////////////////////////////////////////////

    assign pick_write = !wq_empty && (wq_flush || rq_empty);
    assign wq_pop     = !sq_full && pick_write;
    assign rq_pop     = !sq_full && !rq_empty && !pick_write;
    assign sq_push    = wq_pop || rq_pop;

    always_comb
    begin
        if (pick_write)
            sq_in = wq_head;
        else
            sq_in = '{cmd: rq_head, wdata: '0};
    end

    gc_sync_fifo #(
        .WIDTH ($bits(gc_sched_entry_t)),
        .DEPTH (`GC_FIFO_DEPTH)
    ) sched_queue_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (sq_push),
        .i_pop   (i_sched_pop),
        .i_data  (sq_in),
        .o_data  (o_sched_head),
        .o_empty (o_sched_empty),
        .o_full  (sq_full),
        .o_count ()
    );

    // during a flush only queued writes may move on
    a_flush_writes_only : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (sq_push && wq_flush && !wq_empty) |-> (sq_in.cmd.op == GC_OP_WRITE));

endmodule

// File: verilog/gc_sync_fifo.sv
/*
 * Single-clock FIFO with first-word fall-through: o_data shows the head
 * whenever o_empty is low. The caller must not push when full or pop
 * when empty. Push and pop in one cycle are allowed.
 */
`timescale 1ns/1ns

module gc_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_push,
    input  logic                       i_pop,
    input  logic [WIDTH-1:0]           i_data,
    output logic [WIDTH-1:0]           o_data,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end
        else
        begin
            // wrap by compare so any depth works
            if (i_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (i_push && !i_pop)
                o_count <= o_count + 1'b1;
            else if (i_pop && !i_push)
                o_count <= o_count - 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];
    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == CW'(DEPTH));

    a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_push && o_full));
    a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_pop && o_empty));

endmodule

// File: verilog/gc_write_queue.sv
/*
 * Write queue with a valid bit per slot so a queued write can be matched
 * against a read address. Entries leave in arrival order. The flush flag
 * holds until the queue is empty.
 */
`timescale 1ns/1ns

`include "gc_cfg.svh"

module gc_write_queue import gc_cmd_pkg::*, gc_bank_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_push,
    input  gc_front_cmd_t   i_cmd,
    input  gc_word_t        i_wdata,
    input  logic            i_pop,
    input  gc_front_cmd_t   i_raw_probe,
    input  logic            i_probe_valid,
    output gc_sched_entry_t o_head,
    output logic            o_empty,
    output logic            o_full,
    output logic            o_flush
);

    localparam int DEPTH = `GC_WQ_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    typedef enum logic
    {
        WQ_ACCEPT,
        WQ_FLUSH
    } wq_state_e;

    wq_state_e       state;
    gc_sched_entry_t slot [DEPTH];
    logic [DEPTH-1:0] slot_valid;
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            raw_hit;
    logic            at_level;

    ////////////////////////////////////////////////////////////////////////////
    // slot bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            slot_valid <= '0;
        end
        else
        begin
            if (i_push)
            begin
                slot_valid[wr_ptr] <= 1'b1;
                wr_ptr             <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop)
            begin
                slot_valid[rd_ptr] <= 1'b0;
                rd_ptr             <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            slot[wr_ptr] <= '{cmd: i_cmd, wdata: i_wdata};
    end

    assign o_head  = slot[rd_ptr];
    assign o_empty = !slot_valid[rd_ptr];
    assign o_full  = slot_valid[wr_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // read-after-write match and flush FSM
    ////////////////////////////////////////////////////////////////////////////

    // row, column and bank must all match
    always_comb
    begin
        raw_hit = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (slot_valid[i] && slot[i].cmd.row == i_raw_probe.row &&
                slot[i].cmd.col == i_raw_probe.col && slot[i].cmd.bank == i_raw_probe.bank)
                raw_hit = i_probe_valid;
        end
    end

    assign at_level = ($countones(slot_valid) >= CW'(`GC_WQ_FLUSH_LEVEL));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            state <= WQ_ACCEPT;
        else
        begin
            case (state)
                WQ_ACCEPT:
                begin
                    if (raw_hit || at_level)
                        state <= WQ_FLUSH;
                end
                WQ_FLUSH:
                begin
                    if (o_empty)
                        state <= WQ_ACCEPT;
                end
                default:
                    state <= WQ_ACCEPT;
            endcase
        end
    end

    assign o_flush = (state == WQ_FLUSH);

endmodule
